// ==== multicycle_ctrl.f ====
+incdir+.
ctrl_pkg.sv
instr_decoder.sv
step_sequencer.sv
control_word_gen.sv
multicycle_ctrl.sv
tb_multicycle_ctrl.sv

// ==== Bender.yml ====
package:
  name: multicycle_ctrl

sources:
  - ctrl_pkg.sv
  - instr_decoder.sv
  - step_sequencer.sv
  - control_word_gen.sv
  - multicycle_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_multicycle_ctrl.sv

// ==== tb_tasks.svh ====
// Expected ALU setup per op: ADD SUB AND OR SLT ADDI ANDI ORI SLTI
localparam logic [0:8][5:0] ALU_OPCODES = {OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_RTYPE,
                                           OP_RTYPE, OP_ADDI, OP_ANDI, OP_ORI, OP_SLTI};
localparam logic [0:8][5:0] ALU_FUNCTS  = {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT,
                                           6'd0, 6'd0, 6'd0, 6'd0};
localparam logic [0:8][2:0] ALU_CODES   = {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT,
                                           ALU_ADD, ALU_AND, ALU_OR, ALU_SLT};

// ADD, SUB and ADDI trap on overflow, AND does not
localparam logic [0:3][5:0] OVF_OPCODES = {OP_RTYPE, OP_RTYPE, OP_ADDI, OP_RTYPE};
localparam logic [0:3][5:0] OVF_FUNCTS  = {FN_ADD, FN_SUB, 6'd0, FN_AND};

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic advance();
    @(negedge clk);
    seen = ctrl;
    cyc++;
endtask

task automatic compare_field(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
        $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        test_errs++;
    end
endtask

task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
endtask

task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
        $display("[TEST] %s: ok", test_name);
    end else begin
        tests_failed++;
        $display("[TEST] %s: %0d errors", test_name, test_errs);
    end
endtask

// Present an instruction in the decode cycle and sample that cycle
task automatic issue(input logic [5:0] op, input logic [5:0] fn);
    @(posedge clk);
    instr <= {op, fn};
    advance();
    compare_field("decode A/B write", 2'b11, {seen.wr_a, seen.wr_b});
endtask

task automatic wait_fetch();
    int n;
    n = 0;
    do begin
        advance();
        n++;
    end while (!seen.ir_wr && n < 40);
    if (!seen.ir_wr) begin
        $display("%s: no instruction fetch within 40 cycles", test_name);
        test_errs++;
    end
    prev_fetch = last_fetch;
    last_fetch = cyc;
endtask

task automatic reset_fetch_test();
    start_test("reset_fetch");
    repeat (RESET_CYCLES) begin
        advance();
        compare_field("ctrl in reset", '0, seen);
    end
    @(posedge clk);
    reset <= 1'b0;
    advance();
    compare_field("ctrl in idle", '0, seen);
    advance();
    compare_field("fetch alu_out_wr", 1, seen.alu_out_wr);
    compare_field("fetch src_a", SRC_A_PC, seen.alu_src_a);
    compare_field("fetch src_b", SRC_B_FOUR, seen.alu_src_b);
    compare_field("fetch alu_op", ALU_ADD, seen.alu_op);
    advance();
    compare_field("fetch ir_wr", 1, seen.ir_wr);
    compare_field("fetch pc_wr", 1, seen.pc_wr);
    compare_field("fetch pc_source", PC_ALU_RESULT, seen.pc_source);
    last_fetch = cyc;
    end_test();
endtask

task automatic alu_test();
    int pick;
    start_test("alu_ops");
    repeat (8) begin
        pick = int'(xorshift32() % 9);
        issue(ALU_OPCODES[pick], ALU_FUNCTS[pick]);
        advance();
        compare_field("exec alu_op", ALU_CODES[pick], seen.alu_op);
        compare_field("exec src_a", SRC_A_REG, seen.alu_src_a);
        compare_field("exec src_b", (pick < 5) ? SRC_B_REG : SRC_B_IMM, seen.alu_src_b);
        advance();
        compare_field("check reg_wr", 0, seen.reg_wr);
        advance();
        compare_field("writeback reg_wr", 1, seen.reg_wr);
        compare_field("writeback reg_dst", (pick < 5) ? DST_RD : DST_RT, seen.reg_dst);
        compare_field("writeback source", WB_ALU_OUT, seen.mem_to_reg);
        wait_fetch();
        compare_field("fetch spacing", 6, last_fetch - prev_fetch);
    end
    end_test();
endtask

task automatic exception_test();
    start_test("exceptions");
    for (int i = 0; i < 4; i++) begin
        issue(OVF_OPCODES[i], OVF_FUNCTS[i]);
        advance();
        @(posedge clk);
        flags.overflow <= 1'b1;
        advance();
        @(posedge clk);
        flags.overflow <= 1'b0;
        advance();
        if (i < 3) begin
            compare_field("overflow reg_wr", 0, seen.reg_wr);
            compare_field("overflow epc_wr", 1, seen.epc_wr);
            compare_field("overflow pc_wr", 1, seen.pc_wr);
            compare_field("overflow pc_source", PC_EXC_VECTOR, seen.pc_source);
            compare_field("overflow cause", CAUSE_OVERFLOW, seen.cause);
        end else begin
            compare_field("AND overflow reg_wr", 1, seen.reg_wr);
            compare_field("AND overflow epc_wr", 0, seen.epc_wr);
        end
        wait_fetch();
    end
    // Undefined opcode, then undefined funct under R-type
    for (int i = 0; i < 2; i++) begin
        issue((i == 0) ? 6'b111111 : OP_RTYPE, (i == 0) ? 6'd0 : 6'b000001);
        advance();
        compare_field("invalid epc_wr", 1, seen.epc_wr);
        compare_field("invalid pc_wr", 1, seen.pc_wr);
        compare_field("invalid pc_source", PC_EXC_VECTOR, seen.pc_source);
        compare_field("invalid cause", CAUSE_INVALID, seen.cause);
        compare_field("invalid reg_wr", 0, seen.reg_wr);
        wait_fetch();
    end
    end_test();
endtask

task automatic memory_test();
    start_test("memory");
    for (int i = 0; i < 2; i++) begin
        issue((i == 0) ? OP_LW : OP_LB, 6'd0);
        advance();
        compare_field("address alu_out_wr", 1, seen.alu_out_wr);
        compare_field("address src_b", SRC_B_IMM, seen.alu_src_b);
        compare_field("address alu_op", ALU_ADD, seen.alu_op);
        repeat (1 + MEM_LATENCY) begin
            advance();
            compare_field("load_ctrl before format", LOAD_NONE, seen.load_ctrl);
        end
        advance();
        compare_field("load format", (i == 0) ? LOAD_WORD : LOAD_BYTE, seen.load_ctrl);
        advance();
        compare_field("load reg_wr", 1, seen.reg_wr);
        compare_field("load source", WB_MDR, seen.mem_to_reg);
        compare_field("load reg_dst", DST_RT, seen.reg_dst);
        wait_fetch();
    end
    issue(OP_SW, 6'd0);
    advance();
    advance();
    compare_field("store mem_wr", 1, seen.mem_wr);
    compare_field("store iord", ADDR_ALU_OUT, seen.iord);
    compare_field("store reg_wr", 0, seen.reg_wr);
    wait_fetch();
    end_test();
endtask

task automatic control_flow_test();
    logic z;
    logic taken;
    start_test("control_flow");
    for (int i = 0; i < 4; i++) begin
        z = i[0];
        taken = (i < 2) ? z : !z;
        issue((i < 2) ? OP_BEQ : OP_BNE, 6'd0);
        @(posedge clk);
        flags.zero <= z;
        advance();
        advance();
        compare_field("branch pc_wr", taken, seen.pc_wr);
        if (taken) begin
            compare_field("branch pc_source", PC_BRANCH_TARGET, seen.pc_source);
        end
        wait_fetch();
    end
    issue(OP_J, 6'd0);
    advance();
    compare_field("J pc_wr", 1, seen.pc_wr);
    compare_field("J pc_source", PC_JUMP_TARGET, seen.pc_source);
    wait_fetch();
    issue(OP_RTYPE, FN_JR);
    advance();
    compare_field("JR pc_wr", 1, seen.pc_wr);
    compare_field("JR pc_source", PC_REG_A, seen.pc_source);
    wait_fetch();
    issue(OP_JAL, 6'd0);
    advance();
    compare_field("JAL link reg_wr", 1, seen.reg_wr);
    compare_field("JAL link reg_dst", DST_RA31, seen.reg_dst);
    compare_field("JAL link source", WB_PC, seen.mem_to_reg);
    compare_field("JAL link pc_wr", 0, seen.pc_wr);
    advance();
    compare_field("JAL jump pc_wr", 1, seen.pc_wr);
    compare_field("JAL jump pc_source", PC_JUMP_TARGET, seen.pc_source);
    wait_fetch();
    end_test();
endtask

task automatic mult_div_test();
    logic is_div;
    logic dz;
    int   waits;
    start_test("mult_div");
    for (int i = 0; i < 3; i++) begin
        is_div = (i > 0);
        dz = (i == 2);
        waits = int'(xorshift32() % 5) + 1;
        issue(OP_RTYPE, is_div ? FN_DIV : FN_MULT);
        advance();
        compare_field("mult_start", !is_div, seen.mult_start);
        compare_field("div_start", is_div, seen.div_start);
        for (int w = 1; w <= waits; w++) begin
            @(posedge clk);
            if (w == waits) begin
                if (is_div) begin
                    md.div_ready <= 1'b1;
                end else begin
                    md.mult_ready <= 1'b1;
                end
                md.div_zero <= dz;
            end
            advance();
            compare_field("lo_wr while waiting", 0, seen.lo_wr);
            compare_field("hi_wr while waiting", 0, seen.hi_wr);
        end
        @(posedge clk);
        md <= '0;
        advance();
        if (dz) begin
            compare_field("div zero epc_wr", 1, seen.epc_wr);
            compare_field("div zero cause", CAUSE_DIV_ZERO, seen.cause);
            compare_field("div zero lo_wr", 0, seen.lo_wr);
            compare_field("div zero hi_wr", 0, seen.hi_wr);
        end else begin
            compare_field("result lo_wr", 1, seen.lo_wr);
            compare_field("result hi_wr", 1, seen.hi_wr);
        end
        wait_fetch();
    end
    end_test();
endtask

task automatic hilo_move_test();
    start_test("hilo_move");
    for (int i = 0; i < 2; i++) begin
        issue(OP_RTYPE, (i == 0) ? FN_MFHI : FN_MFLO);
        advance();
        compare_field("move reg_wr", 1, seen.reg_wr);
        compare_field("move reg_dst", DST_RD, seen.reg_dst);
        compare_field("move source", (i == 0) ? WB_HI : WB_LO, seen.mem_to_reg);
        wait_fetch();
    end
    end_test();
endtask

// ==== tb_multicycle_ctrl.sv ====
module tb_multicycle_ctrl
    import ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int MEM_LATENCY  = 2;
    localparam int RESET_CYCLES = 8;

    // Cycle budget per test group, fetch included, longest mult/div wait assumed
    localparam int WORST_CYCLES = (RESET_CYCLES + 3)
                                + 8 * 6
                                + 6 * 6
                                + 2 * (8 + MEM_LATENCY) + 5
                                + 7 * 5
                                + 3 * 11
                                + 2 * 4;
    localparam int MARGIN_CYCLES = 50;

    logic          clk;
    logic          reset;
    instr_fields_t instr;
    alu_flags_t    flags;
    md_status_t    md;
    ctrl_word_t    ctrl;

    // Last sampled control word and bookkeeping
    ctrl_word_t  seen;
    int          cyc;
    int          last_fetch;
    int          prev_fetch;
    string       test_name;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int          total_errs;
    logic [31:0] rng_state;

    multicycle_ctrl #(
        .MEM_LATENCY (MEM_LATENCY)
    ) UUT (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .flags (flags),
        .md    (md),
        .ctrl  (ctrl)
    );

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #((WORST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles in test %s",
                 WORST_CYCLES + MARGIN_CYCLES, test_name);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        instr        = '0;
        flags        = '0;
        md           = '0;
        seen         = '0;
        cyc          = 0;
        last_fetch   = 0;
        prev_fetch   = 0;
        test_name    = "none";
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_errs   = 0;
        rng_state    = 32'd38874;

        reset_fetch_test();
        alu_test();
        exception_test();
        memory_test();
        control_flow_test();
        mult_div_test();
        hilo_move_test();

        $display("Tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== multicycle_ctrl.sv ====
module multicycle_ctrl import ctrl_pkg::*; #(
    parameter int unsigned MEM_LATENCY = 1
) (
    input  logic          clk,
    input  logic          reset,
    input  instr_fields_t instr,
    input  alu_flags_t    flags,
    input  md_status_t    md,
    output ctrl_word_t    ctrl
);

    decoded_t     decoded;
    instr_class_t cls;
    phase_t       phase;

    instr_decoder u_decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    step_sequencer #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_sequencer (
        .clk     (clk),
        .reset   (reset),
        .decoded (decoded),
        .flags   (flags),
        .md      (md),
        .cls     (cls),
        .phase   (phase)
    );

    // Byte select comes from the live IR, which holds until the next fetch
    control_word_gen u_ctrl_gen (
        .cls       (cls),
        .load_byte (decoded.load_byte),
        .phase     (phase),
        .zero      (flags.zero),
        .ctrl      (ctrl)
    );

endmodule

// ==== control_word_gen.sv ====
module control_word_gen import ctrl_pkg::*; (
    input  instr_class_t cls,
    input  logic         load_byte,
    input  phase_t       phase,
    input  logic         zero,
    output ctrl_word_t   ctrl
);

    alu_op_t  exec_op;
    src_b_t   exec_src_b;
    reg_dst_t exec_dst;
    cause_t   exc_cause;

    // Per-class ALU setup for execute, address and compare steps
    always_comb begin
        exec_op    = ALU_ADD;
        exec_src_b = SRC_B_REG;
        case (cls)
            CLS_SUB, CLS_BEQ, CLS_BNE: exec_op = ALU_SUB;
            CLS_AND, CLS_ANDI:         exec_op = ALU_AND;
            CLS_OR, CLS_ORI:           exec_op = ALU_OR;
            CLS_SLT, CLS_SLTI:         exec_op = ALU_SLT;
            default:                   exec_op = ALU_ADD;
        endcase
        if (cls inside {CLS_ADDI, CLS_ANDI, CLS_ORI, CLS_SLTI, CLS_LOAD, CLS_SW}) begin
            exec_src_b = SRC_B_IMM;
        end
    end

    // R-type results go to rd, immediates and loads to rt
    assign exec_dst = (cls inside {CLS_ADD, CLS_SUB, CLS_AND, CLS_OR, CLS_SLT,
                                   CLS_MFHI, CLS_MFLO}) ? DST_RD : DST_RT;

    always_comb begin
        case (cls)
            CLS_DIV:     exc_cause = CAUSE_DIV_ZERO;
            CLS_INVALID: exc_cause = CAUSE_INVALID;
            default:     exc_cause = CAUSE_OVERFLOW;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (phase)
            PH_FETCH_PC: begin
                // ALUOut = PC + 4
                ctrl.alu_src_a  = SRC_A_PC;
                ctrl.alu_src_b  = SRC_B_FOUR;
                ctrl.alu_op     = ALU_ADD;
                ctrl.alu_out_wr = 1'b1;
            end
            PH_FETCH_IR: begin
                ctrl.iord      = ADDR_PC;
                ctrl.ir_wr     = 1'b1;
                ctrl.pc_source = PC_ALU_RESULT;
                ctrl.pc_wr     = 1'b1;
            end
            PH_DECODE: begin
                // Register read plus branch target into ALUOut
                ctrl.wr_a       = 1'b1;
                ctrl.wr_b       = 1'b1;
                ctrl.alu_src_a  = SRC_A_PC;
                ctrl.alu_src_b  = SRC_B_IMM_SHIFTED;
                ctrl.alu_op     = ALU_ADD;
                ctrl.alu_out_wr = 1'b1;
            end
            PH_EXEC, PH_MEM_ADDR: begin
                ctrl.alu_src_a  = SRC_A_REG;
                ctrl.alu_src_b  = exec_src_b;
                ctrl.alu_op     = exec_op;
                ctrl.alu_out_wr = 1'b1;
            end
            PH_CHECK, PH_COMPARE: begin
                // Operands stay on the ALU so the flags remain valid
                ctrl.alu_src_a = SRC_A_REG;
                ctrl.alu_src_b = exec_src_b;
                ctrl.alu_op    = exec_op;
            end
            PH_BRANCH: begin
                ctrl.alu_src_a = SRC_A_REG;
                ctrl.alu_src_b = exec_src_b;
                ctrl.alu_op    = exec_op;
                ctrl.pc_source = PC_BRANCH_TARGET;
                ctrl.pc_wr     = (cls == CLS_BEQ) ? zero : !zero;
            end
            PH_MEM_ACCESS: begin
                ctrl.iord   = ADDR_ALU_OUT;
                ctrl.mem_wr = (cls == CLS_SW);
            end
            PH_MEM_WAIT: ctrl.iord = ADDR_ALU_OUT;
            PH_LOAD_FORMAT: ctrl.load_ctrl = load_byte ? LOAD_BYTE : LOAD_WORD;
            PH_WRITEBACK: begin
                ctrl.reg_wr  = 1'b1;
                ctrl.reg_dst = exec_dst;
                case (cls)
                    CLS_LOAD: ctrl.mem_to_reg = WB_MDR;
                    CLS_MFHI: ctrl.mem_to_reg = WB_HI;
                    CLS_MFLO: ctrl.mem_to_reg = WB_LO;
                    default:  ctrl.mem_to_reg = WB_ALU_OUT;
                endcase
            end
            PH_MD_START: begin
                ctrl.mult_start = (cls == CLS_MULT);
                ctrl.div_start  = (cls == CLS_DIV);
            end
            PH_MD_WRITE: begin
                ctrl.lo_wr = 1'b1;
                ctrl.hi_wr = 1'b1;
            end
            PH_LINK: begin
                // Return address into r31
                ctrl.reg_wr     = 1'b1;
                ctrl.reg_dst    = DST_RA31;
                ctrl.mem_to_reg = WB_PC;
            end
            PH_JUMP: begin
                ctrl.pc_source = (cls == CLS_JR) ? PC_REG_A : PC_JUMP_TARGET;
                ctrl.pc_wr     = 1'b1;
            end
            PH_EXCEPTION: begin
                ctrl.epc_wr    = 1'b1;
                ctrl.pc_source = PC_EXC_VECTOR;
                ctrl.pc_wr     = 1'b1;
                ctrl.cause     = exc_cause;
            end
            default: ctrl = '0;
        endcase
    end

    always_comb begin
        assert final (!(ctrl.mem_wr && ctrl.reg_wr))
            else $error("memory write and register write in the same step");
        assert final (!ctrl.ir_wr || phase == PH_FETCH_IR)
            else $error("IR write outside fetch in phase %s", phase.name());
    end

endmodule

// ==== step_sequencer.sv ====
module step_sequencer import ctrl_pkg::*; #(
    parameter int unsigned MEM_LATENCY = 1
) (
    input  logic         clk,
    input  logic         reset,
    input  decoded_t     decoded,
    input  alu_flags_t   flags,
    input  md_status_t   md,
    output instr_class_t cls,
    output phase_t       phase
);

    localparam logic [2:0] LAST_WAIT = (MEM_LATENCY == 0) ? 3'd0 : 3'(MEM_LATENCY - 1);

    logic [2:0] wait_cnt;
    logic       overflow_trap;
    logic       md_ready;

    // Only the signed adds trap on overflow
    assign overflow_trap = flags.overflow && (cls inside {CLS_ADD, CLS_SUB, CLS_ADDI});
    assign md_ready      = (cls == CLS_MULT) ? md.mult_ready : md.div_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase    <= PH_IDLE;
            cls      <= CLS_INVALID;
            wait_cnt <= 3'd0;
        end else begin
            case (phase)
                PH_IDLE:     phase <= PH_FETCH_PC;
                PH_FETCH_PC: phase <= PH_FETCH_IR;
                PH_FETCH_IR: phase <= PH_DECODE;
                PH_DECODE: begin
                    // Class is held from here to the end of the instruction
                    cls <= decoded.cls;
                    if (decoded.invalid) begin
                        phase <= PH_EXCEPTION;
                    end else begin
                        case (decoded.cls)
                            CLS_ADD, CLS_SUB, CLS_AND, CLS_OR, CLS_SLT,
                            CLS_ADDI, CLS_ANDI, CLS_ORI, CLS_SLTI:
                                phase <= PH_EXEC;
                            CLS_MFHI, CLS_MFLO:
                                phase <= PH_WRITEBACK;
                            CLS_J, CLS_JR:
                                phase <= PH_JUMP;
                            CLS_JAL:
                                phase <= PH_LINK;
                            CLS_BEQ, CLS_BNE:
                                phase <= PH_COMPARE;
                            CLS_LOAD, CLS_SW:
                                phase <= PH_MEM_ADDR;
                            CLS_MULT, CLS_DIV:
                                phase <= PH_MD_START;
                            default:
                                phase <= PH_EXCEPTION;
                        endcase
                    end
                end
                PH_EXEC: phase <= PH_CHECK;
                PH_CHECK: begin
                    if (overflow_trap) begin
                        phase <= PH_EXCEPTION;
                    end else begin
                        phase <= PH_WRITEBACK;
                    end
                end
                PH_MEM_ADDR: phase <= PH_MEM_ACCESS;
                PH_MEM_ACCESS: begin
                    wait_cnt <= 3'd0;
                    if (cls == CLS_SW) begin
                        phase <= PH_FETCH_PC;
                    end else if (MEM_LATENCY == 0) begin
                        phase <= PH_LOAD_FORMAT;
                    end else begin
                        phase <= PH_MEM_WAIT;
                    end
                end
                PH_MEM_WAIT: begin
                    if (wait_cnt == LAST_WAIT) begin
                        phase <= PH_LOAD_FORMAT;
                    end else begin
                        wait_cnt <= wait_cnt + 3'd1;
                    end
                end
                PH_LOAD_FORMAT: phase <= PH_WRITEBACK;
                PH_MD_START:    phase <= PH_MD_WAIT;
                PH_MD_WAIT: begin
                    // Hold until the unit reports ready
                    if (md_ready) begin
                        if (cls == CLS_DIV && md.div_zero) begin
                            phase <= PH_EXCEPTION;
                        end else begin
                            phase <= PH_MD_WRITE;
                        end
                    end
                end
                PH_COMPARE: phase <= PH_BRANCH;
                PH_LINK:    phase <= PH_JUMP;
                PH_WRITEBACK, PH_MD_WRITE, PH_BRANCH, PH_JUMP, PH_EXCEPTION:
                    phase <= PH_FETCH_PC;
                default:    phase <= PH_IDLE;
            endcase
        end
    end

    md_wait_class_chk: assert property (@(posedge clk) disable iff (reset)
        phase == PH_MD_WAIT |-> cls inside {CLS_MULT, CLS_DIV})
        else $error("mult/div wait with class %s", cls.name());

    exc_exit_chk: assert property (@(posedge clk) disable iff (reset)
        phase == PH_EXCEPTION |=> phase == PH_FETCH_PC)
        else $error("exception not followed by fetch");

endmodule

// ==== instr_decoder.sv ====
module instr_decoder import ctrl_pkg::*; (
    input  instr_fields_t instr,
    output decoded_t      decoded
);

    instr_class_t cls;

    always_comb begin
        cls = CLS_INVALID;
        case (instr.opcode)
            OP_RTYPE: begin
                case (instr.funct)
                    FN_ADD:  cls = CLS_ADD;
                    FN_SUB:  cls = CLS_SUB;
                    FN_AND:  cls = CLS_AND;
                    FN_OR:   cls = CLS_OR;
                    FN_SLT:  cls = CLS_SLT;
                    FN_MULT: cls = CLS_MULT;
                    FN_DIV:  cls = CLS_DIV;
                    FN_MFHI: cls = CLS_MFHI;
                    FN_MFLO: cls = CLS_MFLO;
                    FN_JR:   cls = CLS_JR;
                    default: cls = CLS_INVALID;
                endcase
            end
            OP_LW:   cls = CLS_LOAD;
            OP_LB:   cls = CLS_LOAD;
            OP_SW:   cls = CLS_SW;
            OP_ADDI: cls = CLS_ADDI;
            OP_ANDI: cls = CLS_ANDI;
            OP_ORI:  cls = CLS_ORI;
            OP_SLTI: cls = CLS_SLTI;
            OP_BEQ:  cls = CLS_BEQ;
            OP_BNE:  cls = CLS_BNE;
            OP_J:    cls = CLS_J;
            OP_JAL:  cls = CLS_JAL;
            default: cls = CLS_INVALID;
        endcase
    end

    assign decoded.cls       = cls;
    assign decoded.load_byte = (instr.opcode == OP_LB);
    assign decoded.invalid   = (cls == CLS_INVALID);

endmodule

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

    // Primary opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_LB    = 6'b100000,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    // Function codes under OP_RTYPE
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_MFHI = 6'b010000,
        FN_MFLO = 6'b010010,
        FN_MULT = 6'b011000,
        FN_DIV  = 6'b011010,
        FN_ADD  = 6'b100000,
        FN_SUB  = 6'b100010,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_SLT  = 6'b101010
    } funct_t;

    // Raw IR fields, kept as plain bits so undefined codes can be presented
    typedef struct packed {
        logic [5:0] opcode;
        logic [5:0] funct;
    } instr_fields_t;

    // LW and LB share CLS_LOAD, the width comes from load_byte
    typedef enum logic [4:0] {
        CLS_INVALID, CLS_ADD, CLS_SUB, CLS_AND, CLS_OR, CLS_SLT,
        CLS_MULT, CLS_DIV, CLS_MFHI, CLS_MFLO, CLS_JR,
        CLS_LOAD, CLS_SW, CLS_ADDI, CLS_ANDI, CLS_ORI, CLS_SLTI,
        CLS_BEQ, CLS_BNE, CLS_J, CLS_JAL
    } instr_class_t;

    typedef struct packed {
        instr_class_t cls;
        logic         load_byte;
        logic         invalid;
    } decoded_t;

    typedef enum logic [4:0] {
        PH_IDLE, PH_FETCH_PC, PH_FETCH_IR, PH_DECODE,
        PH_EXEC, PH_CHECK, PH_WRITEBACK,
        PH_MEM_ADDR, PH_MEM_ACCESS, PH_MEM_WAIT, PH_LOAD_FORMAT,
        PH_MD_START, PH_MD_WAIT, PH_MD_WRITE,
        PH_COMPARE, PH_BRANCH, PH_LINK, PH_JUMP, PH_EXCEPTION
    } phase_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b001,
        ALU_SUB = 3'b010,
        ALU_AND = 3'b011,
        ALU_OR  = 3'b100,
        ALU_SLT = 3'b101
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_A_PC  = 2'b00,
        SRC_A_REG = 2'b10
    } src_a_t;

    typedef enum logic [1:0] {
        SRC_B_REG         = 2'b00,
        SRC_B_FOUR        = 2'b01,
        SRC_B_IMM         = 2'b10,
        SRC_B_IMM_SHIFTED = 2'b11
    } src_b_t;

    typedef enum logic [2:0] {
        ADDR_PC      = 3'b000,
        ADDR_ALU_OUT = 3'b100
    } addr_sel_t;

    typedef enum logic [2:0] {
        WB_MDR     = 3'b010,
        WB_ALU_OUT = 3'b011,
        WB_HI      = 3'b100,
        WB_LO      = 3'b101,
        WB_PC      = 3'b110
    } wb_sel_t;

    typedef enum logic [1:0] {
        DST_RT   = 2'b00,
        DST_RD   = 2'b01,
        DST_RA31 = 2'b10
    } reg_dst_t;

    typedef enum logic [2:0] {
        PC_ALU_RESULT    = 3'b000,
        PC_BRANCH_TARGET = 3'b001,
        PC_REG_A         = 3'b010,
        PC_JUMP_TARGET   = 3'b011,
        PC_EXC_VECTOR    = 3'b100
    } pc_src_t;

    typedef enum logic [1:0] {
        CAUSE_OVERFLOW = 2'd0,
        CAUSE_DIV_ZERO = 2'd1,
        CAUSE_INVALID  = 2'd2
    } cause_t;

    typedef enum logic [1:0] {
        LOAD_NONE = 2'b00,
        LOAD_BYTE = 2'b01,
        LOAD_WORD = 2'b10
    } load_ctrl_t;

    typedef struct packed {
        logic       mem_wr;
        logic       ir_wr;
        logic       reg_wr;
        logic       wr_a;
        logic       wr_b;
        logic       alu_out_wr;
        logic       pc_wr;
        logic       epc_wr;
        logic       mult_start;
        logic       div_start;
        logic       lo_wr;
        logic       hi_wr;
        addr_sel_t  iord;
        wb_sel_t    mem_to_reg;
        reg_dst_t   reg_dst;
        src_a_t     alu_src_a;
        src_b_t     alu_src_b;
        alu_op_t    alu_op;
        pc_src_t    pc_source;
        cause_t     cause;
        load_ctrl_t load_ctrl;
    } ctrl_word_t;

    typedef struct packed {
        logic overflow;
        logic zero;
    } alu_flags_t;

    typedef struct packed {
        logic mult_ready;
        logic div_ready;
        logic div_zero;
    } md_status_t;

endpackage
